// ==== logic/snes_cart_pkg.sv ====
`default_nettype none

package snes_cart_pkg;

	// ========================================================================
	// Download stream
	// ========================================================================
	localparam int DL_ADDR_W = 25;
	localparam int DL_DATA_W = 16;

	// Index values from the host
	localparam logic [5:0] IDX_CART = 6'd0;
	localparam logic [7:0] IDX_CODE = 8'hFF;

	// ========================================================================
	// ROM header
	// ========================================================================
	// Copier header in front of the image
	localparam logic [DL_ADDR_W-1:0] HDR_SKIP         = 25'h200;
	localparam logic [DL_ADDR_W-1:0] HDR_LOROM_ADDR   = 25'h7FD6;
	localparam logic [DL_ADDR_W-1:0] HDR_HIROM_ADDR   = 25'hFFD6;
	localparam logic [DL_ADDR_W-1:0] HDR_EXHIROM_ADDR = 25'h40FFD6;
	// RAM size follows the ROM size field
	localparam logic [DL_ADDR_W-1:0] HDR_RAM_GAP      = 25'd2;

	localparam logic [3:0] DEF_ROM_SIZE = 4'd12;

	localparam int                MASK_W    = 24;
	localparam logic [MASK_W-1:0] MASK_BASE = 24'd1024;

	localparam logic [2:0] HDR_AUTO    = 3'd0;
	localparam logic [2:0] HDR_NONE    = 3'd1;
	localparam logic [2:0] HDR_LOROM   = 3'd2;
	localparam logic [2:0] HDR_HIROM   = 3'd3;
	localparam logic [2:0] HDR_EXHIROM = 3'd4;

	// ========================================================================
	// WRAM fill
	// ========================================================================
	localparam int FILL_ADDR_W = 17;

	localparam logic [7:0] FILL_BYTE_A = 8'h66;
	localparam logic [7:0] FILL_BYTE_B = 8'h99;
	localparam logic [7:0] FILL_BYTE_C = 8'h55;

	localparam logic [1:0] FILL_9966 = 2'd0;
	localparam logic [1:0] FILL_00FF = 2'd1;
	localparam logic [1:0] FILL_55   = 2'd2;
	localparam logic [1:0] FILL_FF   = 2'd3;

	// Cheat code, loaded as words and consumed as fields
	typedef union packed {
		logic [7:0][15:0] words;
		struct packed {
			logic [31:0] flags;
			logic [31:0] address;
			logic [31:0] compare;
			logic [31:0] replace;
		} fields;
	} cheat_code_t;

endpackage

`default_nettype wire

// ==== logic/load_capture.sv ====
`default_nettype none
`timescale 1ns/10ps

module load_capture (
	input  wire                                 clk_sys,
	input  wire                                 RESET,
	input  wire                                 dl_active,
	input  wire [7:0]                           dl_index,
	input  wire [snes_cart_pkg::DL_ADDR_W-1:0] dl_addr,
	input  wire [snes_cart_pkg::DL_DATA_W-1:0] dl_data,
	input  wire                                 dl_wr,
	output logic [snes_cart_pkg::DL_ADDR_W-1:0] cap_addr,
	output logic [snes_cart_pkg::DL_DATA_W-1:0] cap_data,
	output logic                                cart_wr,
	output logic                                code_wr,
	output logic                                cart_active,
	output logic                                cart_start
);

	import snes_cart_pkg::*;

	logic is_cart;
	logic is_code;

	// Index decode, done once for all later stages
	assign is_cart = dl_active && (dl_index[5:0] == IDX_CART);
	assign is_code = dl_active && (dl_index == IDX_CODE);

	// Address and data words
	always_ff @(posedge clk_sys) begin
		cap_addr <= dl_addr;
		cap_data <= dl_data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_wr     <= 1'b0;
			code_wr     <= 1'b0;
			cart_active <= 1'b0;
			cart_start  <= 1'b0;
		end else begin
			cart_wr     <= is_cart & dl_wr;
			code_wr     <= is_code & dl_wr;
			cart_active <= is_cart;
			// cart_active still holds the previous level here
			cart_start  <= is_cart & ~cart_active;
		end
	end

endmodule

`default_nettype wire

// ==== logic/header_parse.sv ====
`default_nettype none
`timescale 1ns/10ps

module header_parse (
	input  wire                                 clk_sys,
	input  wire                                 RESET,
	input  wire                                 cart_wr,
	input  wire                                 cart_active,
	input  wire [snes_cart_pkg::DL_ADDR_W-1:0] cap_addr,
	input  wire [snes_cart_pkg::DL_DATA_W-1:0] cap_data,
	input  wire [2:0]                           hdr_mode,
	input  wire [1:0]                           region_sel,
	output logic [7:0]                          rom_type,
	output logic [snes_cart_pkg::MASK_W-1:0]    rom_mask,
	output logic [snes_cart_pkg::MASK_W-1:0]    ram_mask,
	output logic                                pal
);

	import snes_cart_pkg::*;

	logic [3:0]           rom_size;
	logic [3:0]           ram_size;
	logic                 rom_region;
	logic                 hdr_valid;
	logic [DL_ADDR_W-1:0] size_addr;
	logic                 mode_fixed;

	// Size field location for the forced header modes
	always_comb begin
		mode_fixed = 1'b1;
		case (hdr_mode)
			HDR_LOROM:   size_addr = HDR_LOROM_ADDR + HDR_SKIP;
			HDR_HIROM:   size_addr = HDR_HIROM_ADDR + HDR_SKIP;
			HDR_EXHIROM: size_addr = HDR_EXHIROM_ADDR + HDR_SKIP;
			default: begin
				mode_fixed = 1'b0;
				size_addr  = '0;
			end
		endcase
	end

	// Size registers
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			if (cap_addr == '0) begin
				rom_size <= DEF_ROM_SIZE;
				ram_size <= 4'd0;
				// Auto mode takes both sizes from the first byte
				if (hdr_mode == HDR_AUTO && cap_data[7:0] != 8'd0)
					{ram_size, rom_size} <= cap_data[7:0];
			end
			if (mode_fixed && cap_addr == size_addr)
				rom_size <= cap_data[11:8];
			if (mode_fixed && cap_addr == size_addr + HDR_RAM_GAP)
				ram_size <= cap_data[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
			hdr_valid  <= 1'b0;
			pal        <= 1'b0;
		end else begin
			if (cart_wr && cap_addr == '0) begin
				hdr_valid <= 1'b1;
				case (hdr_mode)
					HDR_NONE, HDR_LOROM: rom_type <= 8'd0;
					HDR_HIROM:           rom_type <= 8'd1;
					HDR_EXHIROM:         rom_type <= 8'd2;
					default:             rom_type <= cap_data[15:8];
				endcase
			end
			if (cart_wr && cap_addr == DL_ADDR_W'(2))
				rom_region <= cap_data[8];

			// Region only moves between downloads
			if (!cart_active)
				pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

	// ========================================================================
	// Masks
	// ========================================================================
	assign rom_mask = hdr_valid ? (MASK_BASE << rom_size) - MASK_W'(1) : '0;
	assign ram_mask = (hdr_valid && ram_size != 4'd0) ?
		(MASK_BASE << ram_size) - MASK_W'(1) : '0;

endmodule

`default_nettype wire

// ==== logic/cheat_assemble.sv ====
`default_nettype none
`timescale 1ns/10ps

module cheat_assemble (
	input  wire                                 clk_sys,
	input  wire                                 RESET,
	input  wire                                 code_wr,
	input  wire [snes_cart_pkg::DL_ADDR_W-1:0] cap_addr,
	input  wire [snes_cart_pkg::DL_DATA_W-1:0] cap_data,
	output snes_cart_pkg::cheat_code_t          code,
	output logic                                code_valid
);

	import snes_cart_pkg::*;

	logic [2:0] slot;
	logic       even_wr;

	// Offset 4k is the low half of field k, 4k+2 its high half.
	// Field 0 (flags) sits in the top word pair.
	assign slot    = {~cap_addr[3:2], cap_addr[1]};
	assign even_wr = code_wr & ~cap_addr[0];

	always_ff @(posedge clk_sys) begin
		if (even_wr)
			code.words[slot] <= cap_data;
	end

	// Last word completes the code
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= even_wr && (cap_addr[3:0] == 4'd14);
	end

endmodule

`default_nettype wire

// ==== logic/ram_clear.sv ====
`default_nettype none
`timescale 1ns/10ps

module ram_clear (
	input  wire                                   clk_sys,
	input  wire                                   RESET,
	input  wire                                   cart_start,
	input  wire [1:0]                             wram_init,
	output logic [snes_cart_pkg::FILL_ADDR_W-1:0] fill_addr,
	output logic [7:0]                            fill_data,
	output logic                                  fill_we,
	output logic                                  fill_busy
);

	import snes_cart_pkg::*;

	// ========================================================================
	// Sequencer
	// ========================================================================
	// A new cartridge restarts the fill, even mid-way
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			fill_busy <= 1'b0;
			fill_addr <= '0;
		end else if (cart_start) begin
			fill_busy <= 1'b1;
			fill_addr <= '0;
		end else if (fill_busy) begin
			fill_addr <= fill_addr + FILL_ADDR_W'(1);
			if (&fill_addr)
				fill_busy <= 1'b0;
		end
	end

	// One write per cycle while busy
	assign fill_we = fill_busy;

	// ========================================================================
	// Pattern generator
	// ========================================================================
	always_comb begin
		case (wram_init)
			FILL_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? FILL_BYTE_A : FILL_BYTE_B;
			FILL_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			FILL_55:   fill_data = FILL_BYTE_C;
			FILL_FF:   fill_data = 8'hFF;
			default:   fill_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/cart_loader_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module cart_loader_top (
	input  wire                                   clk_sys,
	input  wire                                   RESET,
	input  wire                                   dl_active,
	input  wire [7:0]                             dl_index,
	input  wire [snes_cart_pkg::DL_ADDR_W-1:0]   dl_addr,
	input  wire [snes_cart_pkg::DL_DATA_W-1:0]   dl_data,
	input  wire                                   dl_wr,
	input  wire [2:0]                             hdr_mode,
	input  wire [1:0]                             region_sel,
	input  wire [1:0]                             wram_init,
	output logic [7:0]                            rom_type,
	output logic [snes_cart_pkg::MASK_W-1:0]      rom_mask,
	output logic [snes_cart_pkg::MASK_W-1:0]      ram_mask,
	output logic                                  pal,
	output snes_cart_pkg::cheat_code_t            code,
	output logic                                  code_valid,
	output logic [snes_cart_pkg::FILL_ADDR_W-1:0] fill_addr,
	output logic [7:0]                            fill_data,
	output logic                                  fill_we,
	output logic                                  fill_busy,
	output logic                                  core_reset
);

	import snes_cart_pkg::*;

	logic [DL_ADDR_W-1:0] cap_addr;
	logic [DL_DATA_W-1:0] cap_data;
	logic                 cart_wr;
	logic                 code_wr;
	logic                 cart_active;
	logic                 cart_start;

	// ========================================================================
	// Capture and classify
	// ========================================================================
	load_capture i_load_capture (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.dl_wr       (dl_wr),
		.cap_addr    (cap_addr),
		.cap_data    (cap_data),
		.cart_wr     (cart_wr),
		.code_wr     (code_wr),
		.cart_active (cart_active),
		.cart_start  (cart_start)
	);

	// ========================================================================
	// Back stages
	// ========================================================================
	header_parse i_header_parse (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cart_wr     (cart_wr),
		.cart_active (cart_active),
		.cap_addr    (cap_addr),
		.cap_data    (cap_data),
		.hdr_mode    (hdr_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	cheat_assemble i_cheat_assemble (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.code_wr    (code_wr),
		.cap_addr   (cap_addr),
		.cap_data   (cap_data),
		.code       (code),
		.code_valid (code_valid)
	);

	ram_clear i_ram_clear (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_start (cart_start),
		.wram_init  (wram_init),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data),
		.fill_we    (fill_we),
		.fill_busy  (fill_busy)
	);

	// Core held in reset during download and WRAM fill
	assign core_reset = RESET | cart_active | fill_busy;

endmodule

`default_nettype wire

// ==== sim/cart_loader_asserts.sv ====
`default_nettype none
`timescale 1ns/10ps

module cart_loader_asserts (
	input wire                                   clk_sys,
	input wire                                   RESET,
	input wire                                   cart_start,
	input wire                                   fill_we,
	input wire                                   fill_busy,
	input wire [snes_cart_pkg::FILL_ADDR_W-1:0] fill_addr,
	input wire                                   code_valid
);

	import snes_cart_pkg::*;

	// Writes only inside the fill window
	assert property (@(posedge clk_sys) disable iff (RESET) fill_we |-> fill_busy)
		else $error("fill_we high while fill_busy is low");

	// A restart from cart_start is the only jump
	assert property (@(posedge clk_sys) disable iff (RESET)
		(fill_we && !cart_start) |=>
			(!fill_we || fill_addr == $past(fill_addr) + FILL_ADDR_W'(1)))
		else $error("fill_addr did not step by one between writes");

	assert property (@(posedge clk_sys) disable iff (RESET) code_valid |=> !code_valid)
		else $error("code_valid high for two cycles");

endmodule

`default_nettype wire

// ==== sim/cart_loader_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module cart_loader_tb;

	import snes_cart_pkg::*;

	// Four full fills plus downloads and margin
	localparam int MAX_CYCLES = 700000;
	localparam int FILL_LEN   = 131072;

	logic                 clk_sys;
	logic                 RESET;
	logic                 dl_active;
	logic [7:0]           dl_index;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [DL_DATA_W-1:0] dl_data;
	logic                 dl_wr;
	logic [2:0]           hdr_mode;
	logic [1:0]           region_sel;
	logic [1:0]           wram_init;
	logic [7:0]           rom_type;
	logic [MASK_W-1:0]    rom_mask;
	logic [MASK_W-1:0]    ram_mask;
	logic                 pal;
	cheat_code_t          code;
	logic                 code_valid;
	logic [FILL_ADDR_W-1:0] fill_addr;
	logic [7:0]           fill_data;
	logic                 fill_we;
	logic                 fill_busy;
	logic                 core_reset;

	logic [31:0] rnd;
	int          cycle_count;
	int          fill_count;
	int          code_pulses;

	cart_loader_top i_cart_loader_top (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.dl_wr      (dl_wr),
		.hdr_mode   (hdr_mode),
		.region_sel (region_sel),
		.wram_init  (wram_init),
		.rom_type   (rom_type),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask),
		.pal        (pal),
		.code       (code),
		.code_valid (code_valid),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data),
		.fill_we    (fill_we),
		.fill_busy  (fill_busy),
		.core_reset (core_reset)
	);

	bind ram_clear cart_loader_asserts i_fill_asserts (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_start (cart_start),
		.fill_we    (fill_we),
		.fill_busy  (fill_busy),
		.fill_addr  (fill_addr),
		.code_valid (1'b0)
	);

	bind cheat_assemble cart_loader_asserts i_code_asserts (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_start (1'b0),
		.fill_we    (1'b0),
		.fill_busy  (1'b0),
		.fill_addr  ('0),
		.code_valid (code_valid)
	);

	always #4 clk_sys = ~clk_sys;

	// ========================================================================
	// Reference models
	// ========================================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Size counts in 1 KiB units, so the low 10 + size bits are set
	function automatic logic [MASK_W-1:0] mask_of(input logic [3:0] size);
		logic [MASK_W-1:0] m;
		for (int i = 0; i < MASK_W; i++)
			m[i] = (i < 10 + int'(size));
		return m;
	endfunction

	// Returns type, ROM mask and RAM mask
	function automatic logic [55:0] header_ref(input logic [2:0] mode, input logic [15:0] w0,
			input logic [15:0] wsize, input logic [15:0] wram);
		logic [3:0] rom;
		logic [3:0] ram;
		logic [7:0] typ;
		rom = 4'd12;
		ram = 4'd0;
		typ = 8'd0;
		case (mode)
			HDR_AUTO: begin
				typ = w0[15:8];
				if (w0[7:0] != 8'd0) begin
					rom = w0[3:0];
					ram = w0[7:4];
				end
			end
			HDR_NONE: typ = 8'd0;
			default: begin
				typ = (mode == HDR_LOROM) ? 8'd0 : (mode == HDR_HIROM) ? 8'd1 : 8'd2;
				rom = wsize[11:8];
				ram = wram[3:0];
			end
		endcase
		return {typ, mask_of(rom), (ram == 4'd0) ? 24'd0 : mask_of(ram)};
	endfunction

	function automatic logic [DL_ADDR_W-1:0] size_offset(input logic [2:0] mode);
		case (mode)
			HDR_HIROM:   return HDR_HIROM_ADDR + HDR_SKIP;
			HDR_EXHIROM: return HDR_EXHIROM_ADDR + HDR_SKIP;
			default:     return HDR_LOROM_ADDR + HDR_SKIP;
		endcase
	endfunction

	function automatic logic [7:0] fill_ref(input logic [16:0] a, input logic [1:0] init);
		case (init)
			2'd0:    return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			2'd1:    return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			2'd2:    return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	// Word at offset 4k is the low half of field k
	function automatic logic [127:0] cheat_ref(input logic [7:0][15:0] w);
		return {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
	endfunction

	task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
		if (exp !== act) begin
			$display("error %s: expected %0h, actual %0h", name, exp, act);
			$display(">>> FAIL");
			$fatal(1, "stopping at first error");
		end
	endtask

	// ========================================================================
	// Stream driver
	// ========================================================================
	task automatic dl_begin(input logic [7:0] idx);
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_index  <= idx;
	endtask

	task automatic send_word(input logic [DL_ADDR_W-1:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		dl_addr <= addr;
		dl_data <= data;
		dl_wr   <= 1'b1;
		@(posedge clk_sys);
		dl_wr   <= 1'b0;
	endtask

	// Leaves time for the 2-cycle pipeline and the region update
	task automatic dl_end;
		@(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// Fill data and write count, cheat pulse count
	always @(negedge clk_sys) begin
		if (fill_we) begin
			check("fill_data", 128'(fill_ref(fill_addr, wram_init)), 128'(fill_data));
			fill_count <= (fill_addr == '0) ? 1 : fill_count + 1;
		end
		if (code_valid)
			code_pulses <= code_pulses + 1;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == MAX_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		logic [15:0]      w0;
		logic [15:0]      w2;
		logic [15:0]      wsize;
		logic [15:0]      wram;
		logic [55:0]      exp_hdr;
		logic             exp_pal;
		logic [7:0][15:0] cw;
		logic [127:0]     exp_code;
		int               pulses_before;

		clk_sys     = 1'b0;
		RESET       = 1'b1;
		dl_active   = 1'b0;
		dl_index    = 8'd0;
		dl_addr     = '0;
		dl_data     = '0;
		dl_wr       = 1'b0;
		hdr_mode    = HDR_AUTO;
		region_sel  = 2'd0;
		wram_init   = 2'd0;
		rnd         = 32'd8;
		cycle_count = 0;
		fill_count  = 0;
		code_pulses = 0;

		// Reset values
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check("reset core_reset", 128'(1), 128'(core_reset));
		check("reset code_valid", 128'(0), 128'(code_valid));
		check("reset fill_we", 128'(0), 128'(fill_we));
		check("reset fill_busy", 128'(0), 128'(fill_busy));
		check("reset pal", 128'(0), 128'(pal));
		check("reset rom_type", 128'(0), 128'(rom_type));
		check("reset rom_mask", 128'(0), 128'(rom_mask));
		check("reset ram_mask", 128'(0), 128'(ram_mask));
		repeat (12) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check("idle core_reset", 128'(0), 128'(core_reset));

		// ====================================================================
		// Header modes and region
		// ====================================================================
		for (int m = 0; m < 5; m++) begin
			@(posedge clk_sys);
			hdr_mode   <= 3'(m);
			region_sel <= 2'd0;
			for (int n = 0; n < 4; n++) begin
				rnd   = xorshift32(rnd);
				w0    = rnd[15:0];
				w2    = rnd[31:16];
				rnd   = xorshift32(rnd);
				wsize = rnd[15:0];
				wram  = rnd[31:16];
				// Zero low byte keeps the default sizes in auto mode
				if (n == 0)
					w0[7:0] = 8'd0;
				dl_begin({rnd[1:0], 6'd0});
				send_word('0, w0);
				send_word(DL_ADDR_W'(2), w2);
				send_word(size_offset(3'(m)), wsize);
				send_word(size_offset(3'(m)) + DL_ADDR_W'(2), wram);
				dl_end();
				exp_hdr = header_ref(3'(m), w0, wsize, wram);
				check("hdr rom_type", 128'(exp_hdr[55:48]), 128'(rom_type));
				check("hdr rom_mask", 128'(exp_hdr[47:24]), 128'(rom_mask));
				check("hdr ram_mask", 128'(exp_hdr[23:0]), 128'(ram_mask));
				for (int s = 0; s < 4; s++) begin
					@(posedge clk_sys);
					region_sel <= 2'(s);
					repeat (2) @(posedge clk_sys);
					@(negedge clk_sys);
					exp_pal = (s == 0) ? w2[8] : s[1];
					check("region pal", 128'(exp_pal), 128'(pal));
				end
			end
		end

		// Cheat code of eight random words
		pulses_before = code_pulses;
		dl_begin(IDX_CODE);
		for (int i = 0; i < 8; i++) begin
			rnd   = xorshift32(rnd);
			cw[i] = rnd[15:0];
			send_word(DL_ADDR_W'(2 * i), cw[i]);
		end
		dl_end();
		exp_code = cheat_ref(cw);
		check("cheat pulses", 128'(1), 128'(code_pulses - pulses_before));
		check("cheat flags", 128'(exp_code[127:96]), 128'(code.fields.flags));
		check("cheat address", 128'(exp_code[95:64]), 128'(code.fields.address));
		check("cheat compare", 128'(exp_code[63:32]), 128'(code.fields.compare));
		check("cheat replace", 128'(exp_code[31:0]), 128'(code.fields.replace));

		// ====================================================================
		// WRAM fill for each pattern
		// ====================================================================
		for (int f = 0; f < 4; f++) begin
			@(posedge clk_sys);
			wram_init <= 2'(f);
			dl_active <= 1'b1;
			dl_index  <= 8'h00;
			@(posedge clk_sys);
			@(negedge clk_sys);
			// Download level alone, the fill has not started yet
			check("fill core_reset download", 128'(1), 128'(core_reset));
			@(posedge clk_sys);
			@(negedge clk_sys);
			check("fill first we", 128'(1), 128'(fill_we));
			check("fill first addr", 128'(0), 128'(fill_addr));
			rnd = xorshift32(rnd);
			send_word('0, rnd[15:0]);
			dl_end();
			check("fill core_reset busy", 128'(1), 128'(core_reset));
			while (fill_busy)
				@(negedge clk_sys);
			check("fill writes", 128'(FILL_LEN), 128'(fill_count));
			check("fill core_reset done", 128'(0), 128'(core_reset));
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/snes_cart_pkg.sv
logic/load_capture.sv
logic/header_parse.sv
logic/cheat_assemble.sv
logic/ram_clear.sv
logic/cart_loader_top.sv
sim/cart_loader_asserts.sv
sim/cart_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cart loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cart_loader_tb \
	-f filelist.f -o Vcart_loader_tb > build.log 2>&1; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vcart_loader_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q '>>> FAIL' sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

if [ "$sim_status" -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if ! grep -q '>>> PASS' sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation passed"
exit 0
